//--- Bender.yml
package:
  name: calc

sources:
  - hw/calc_isa_pkg.sv
  - hw/calc_pipe_pkg.sv
  - hw/calc_issue.sv
  - hw/calc_pipe_int.sv
  - hw/calc_pipe_mul.sv
  - hw/calc_pipe_long.sv
  - hw/calc_comp_pipe.sv
  - hw/calc_top.sv
  - target: test
    files:
      - bench/calc_tb_clk.sv
      - bench/calc_tb.sv

//--- bench/calc_tb.sv
// Random self-checking testbench for calc_top, compares writebacks with an in-order register model
`timescale 1ns/1ps

module calc_tb;

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  localparam int mul_latency_p = 3;
  localparam int n_alu_c       = 40;
  localparam int n_mix_c       = 60;
  localparam int n_div_c       = 4;
  localparam int n_race_c      = 40;
  localparam int n_flush_c     = 40;
  localparam int div_cycles_c  = 40;
  // Each fixed op may wait for a full multiply, each divide for a full division
  localparam int cycle_limit_c = 16 + 40
    + (n_alu_c + n_mix_c + n_race_c + n_flush_c + 6 * n_div_c) * (mul_latency_p + 3)
    + (4 * n_div_c + 2 + n_flush_c / 4) * (div_cycles_c + mul_latency_p + 3) + 500;

  typedef struct packed {
    logic                        mul;
    logic [reg_addr_width_c-1:0] rd;
    logic [data_width_c-1:0]     data;
    int                          due;
  } expect_s;

  logic          clk;
  logic          arst_n;
  logic          dispatch_v;
  dispatch_pkt_s dispatch_pkt;
  logic          dispatch_ready;
  logic          flush;
  logic          wb_v;
  wb_pkt_s       wb_pkt;
  logic          long_busy;

  integer                  seed;
  int                      cyc;
  int                      checks;
  int                      errors;
  int                      test_errors;
  int                      test_checks;
  int                      tests_done;
  logic [data_width_c-1:0] committed [32];
  logic [data_width_c-1:0] model [32];
  int                      rd_busy [32];
  expect_s                 exp_q [$];
  logic                    div_pend;
  wb_pkt_s                 div_exp;

  calc_tb_clk #(.period_ns_p(20), .reset_cycles_p(16)) clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  calc_top #(.mul_latency_p(mul_latency_p)) dut_i (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .dispatch_v_i     (dispatch_v),
    .dispatch_pkt_i   (dispatch_pkt),
    .dispatch_ready_o (dispatch_ready),
    .flush_i          (flush),
    .wb_v_o           (wb_v),
    .wb_pkt_o         (wb_pkt),
    .long_busy_o      (long_busy)
  );

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    cyc++;
    #2;
  endtask

  // Writeback check at the falling edge, where all outputs have settled
  task automatic observe();
    @(negedge clk);
    if (exp_q.size() > 0 && exp_q[0].due == cyc)
    begin
      checks++;
      if (!wb_v)
        report_failure($sformatf("no writeback for rd %0d in its fixed slot", exp_q[0].rd));
      else if (wb_pkt.rd_addr != exp_q[0].rd)
        report_mismatch("wb_pkt_o.rd_addr", exp_q[0].rd, wb_pkt.rd_addr);
      else if (wb_pkt.rd_data != exp_q[0].data)
        report_mismatch("wb_pkt_o.rd_data", exp_q[0].data, wb_pkt.rd_data);
      if (exp_q[0].mul)
        rd_busy[exp_q[0].rd]--;
      void'(exp_q.pop_front());
    end
    else if (wb_v)
    begin
      checks++;
      if (!div_pend)
        report_failure($sformatf("unexpected writeback to rd %0d", wb_pkt.rd_addr));
      else
      begin
        if (wb_pkt.rd_addr != div_exp.rd_addr)
          report_mismatch("wb_pkt_o.rd_addr", div_exp.rd_addr, wb_pkt.rd_addr);
        else if (wb_pkt.rd_data != div_exp.rd_data)
          report_mismatch("wb_pkt_o.rd_data", div_exp.rd_data, wb_pkt.rd_data);
        rd_busy[div_exp.rd_addr]--;
        div_pend = 1'b0;
      end
    end
    if (wb_v === 1'b1 && wb_pkt.rd_addr != '0)
      committed[wb_pkt.rd_addr] = wb_pkt.rd_data;
  endtask

  task automatic idle_cycle();
    next_cycle();
    dispatch_v = 1'b0;
    observe();
  endtask

  task automatic drain();
    while (exp_q.size() > 0 || div_pend)
      idle_cycle();
    idle_cycle();
  endtask

  function automatic logic [4:0] rand_reg(input int n);
    return 5'($unsigned($random(seed)) % n);
  endfunction

  function automatic instr_u make_instr(input opcode_e op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [17:0] imm);
    instr_u ins;
    ins = '0;
    if (op == op_addi)
    begin
      ins.itype.opcode = op;
      ins.itype.rd     = rd;
      ins.itype.rs1    = rs1;
      ins.itype.imm    = imm;
    end
    else
    begin
      ins.rtype.opcode = op;
      ins.rtype.rd     = rd;
      ins.rtype.rs1    = rs1;
      ins.rtype.rs2    = rs2;
    end
    return ins;
  endfunction

  function automatic instr_u rand_alu(input logic [4:0] rs1, input int nregs);
    opcode_e op;
    op = opcode_e'(4'($unsigned($random(seed)) % 6));
    return make_instr(op, rand_reg(nregs - 1) + 5'd1, rs1, rand_reg(nregs),
                      18'($random(seed)));
  endfunction

  function automatic bit has_hazard(input instr_u ins);
    bit hz;
    hz = rd_busy[ins.rtype.rd] > 0 || rd_busy[ins.rtype.rs1] > 0;
    if (ins.rtype.opcode != op_addi && rd_busy[ins.rtype.rs2] > 0)
      hz = 1'b1;
    return hz;
  endfunction

  // Updates the program order model once the transfer edge is known
  task automatic record(input instr_u ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [4:0]  rd;
    expect_s     e;
    rd = ins.rtype.rd;
    a  = model[ins.rtype.rs1];
    b  = model[ins.rtype.rs2];
    case (ins.rtype.opcode)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_addi: res = a + {{14{ins.itype.imm[17]}}, ins.itype.imm};
      op_mul:  res = a * b;
      op_div:  res = (b == 0) ? 32'hffff_ffff : a / b;
      op_rem:  res = (b == 0) ? a : a % b;
      default: res = '0;
    endcase
    if (ins.rtype.opcode == op_div || ins.rtype.opcode == op_rem)
    begin
      div_pend        = 1'b1;
      div_exp.rd_addr = rd;
      div_exp.rd_data = res;
      rd_busy[rd]++;
    end
    else
    begin
      e.mul  = (ins.rtype.opcode == op_mul);
      e.rd   = rd;
      e.data = res;
      e.due  = cyc + 1 + mul_latency_p;
      exp_q.push_back(e);
      if (e.mul)
        rd_busy[rd]++;
    end
    if (rd != '0)
      model[rd] = res;
  endtask

  task automatic issue(input instr_u ins);
    bit done;
    while (has_hazard(ins))
      idle_cycle();
    done = 1'b0;
    while (!done)
    begin
      next_cycle();
      dispatch_v         = 1'b1;
      dispatch_pkt.instr = ins;
      dispatch_pkt.rs1   = committed[ins.rtype.rs1];
      dispatch_pkt.rs2   = committed[ins.rtype.rs2];
      observe();
      if (dispatch_ready)
      begin
        record(ins);
        done = 1'b1;
      end
    end
  endtask

  // Anything left in flight is cancelled and the model restarts from the committed file
  task automatic flush_cycle();
    next_cycle();
    dispatch_v = 1'b0;
    flush      = 1'b1;
    observe();
    exp_q.delete();
    div_pend = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      rd_busy[i] = 0;
      model[i]   = committed[i];
    end
    next_cycle();
    flush = 1'b0;
    observe();
  endtask

  task automatic finish_test(input int num, input string name);
    tests_done++;
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial
  begin
    int wd_cycles;
    wd_cycles = 0;
    while (wd_cycles < cycle_limit_c)
    begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_limit_c);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    instr_u     ins;
    logic [4:0] prev_rd;
    int         flush_at;
    seed         = 45;
    cyc          = 0;
    checks       = 0;
    errors       = 0;
    test_checks  = 0;
    test_errors  = 0;
    tests_done   = 0;
    div_pend     = 1'b0;
    div_exp      = '0;
    dispatch_v   = 1'b0;
    dispatch_pkt = '0;
    flush        = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      committed[i] = '0;
      model[i]     = '0;
      rd_busy[i]   = 0;
    end
    @(posedge arst_n);

    // Quiet outputs after reset, then r0 must stay zero through the bypass
    for (int i = 0; i < 8; i++)
    begin
      idle_cycle();
      checks++;
      if (wb_v !== 1'b0)
        report_mismatch("wb_v_o", 0, 32'(wb_v));
      if (long_busy !== 1'b0)
        report_mismatch("long_busy_o", 0, 32'(long_busy));
    end
    issue(make_instr(op_addi, 5'd0, 5'd0, 5'd0, 18'd123));
    issue(make_instr(op_add, 5'd3, 5'd0, 5'd0, '0));
    issue(make_instr(op_addi, 5'd4, 5'd0, 5'd0, 18'd7));
    drain();
    finish_test(6, "reset state and register 0");

    prev_rd = 5'd4;
    for (int i = 0; i < n_alu_c; i++)
    begin
      if (i % 5 == 0)
        ins = make_instr(op_addi, rand_reg(7) + 5'd1, prev_rd, '0, 18'($random(seed)));
      else
        ins = rand_alu(prev_rd, 8);
      issue(ins);
      prev_rd = ins.rtype.rd;
    end
    drain();
    finish_test(1, "dependent ALU chain");

    for (int i = 0; i < n_mix_c; i++)
    begin
      if ($unsigned($random(seed)) % 3 == 0)
        issue(make_instr(op_mul, rand_reg(7) + 5'd1, rand_reg(8), rand_reg(8), '0));
      else
        issue(rand_alu(rand_reg(8), 8));
    end
    drain();
    finish_test(2, "MUL and ALU mix");

    for (int k = 0; k < n_div_c; k++)
    begin
      issue(make_instr(op_addi, 5'd1, 5'd0, '0, 18'($random(seed))));
      issue(make_instr(op_mul, 5'd1, 5'd1, 5'd1, '0));
      issue(make_instr(op_addi, 5'd2, 5'd0, '0, (k == 1) ? 18'd0 : 18'($random(seed))));
      issue(make_instr(op_div, 5'd4, 5'd1, (k == 2) ? 5'd0 : 5'd2, '0));
      // A second divide must be held off while the first one runs
      for (int j = 0; j < 3; j++)
      begin
        next_cycle();
        dispatch_v         = 1'b1;
        dispatch_pkt.instr = make_instr(op_div, 5'd5, 5'd1, 5'd2, '0);
        observe();
        checks++;
        if (dispatch_ready)
          report_failure("dispatch_ready_o high for a DIV while the divider is busy");
        // The divider picks the operation up one cycle after the dispatch edge
        if (j > 0)
        begin
          checks++;
          if (long_busy !== 1'b1)
            report_mismatch("long_busy_o", 1, 32'(long_busy));
        end
      end
      drain();
      issue(make_instr(op_rem, 5'd5, 5'd1, (k == 3) ? 5'd0 : 5'd2, '0));
      drain();
    end
    finish_test(3, "DIV and REM");

    issue(make_instr(op_div, 5'd6, 5'd1, 5'd2, '0));
    for (int i = 0; i < n_race_c; i++)
    begin
      if ($unsigned($random(seed)) % 4 == 0)
        idle_cycle();
      else
        issue(rand_alu(rand_reg(5) + 5'd1, 6));
    end
    drain();
    finish_test(4, "divider against fixed latency writeback");

    flush_at = $unsigned($random(seed)) % (n_flush_c / 2) + 5;
    for (int i = 0; i < n_flush_c; i++)
    begin
      case ($unsigned($random(seed)) % 8)
        0:       issue(make_instr(op_div, rand_reg(7) + 5'd1, rand_reg(8), rand_reg(8), '0));
        1, 2:    issue(make_instr(op_mul, rand_reg(7) + 5'd1, rand_reg(8), rand_reg(8), '0));
        default: issue(rand_alu(rand_reg(8), 8));
      endcase
      if (i == flush_at)
        flush_cycle();
    end
    drain();
    finish_test(5, "flush");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- bench/calc_tb_clk.sv
// Clock and reset source for the execution back end testbench
`timescale 1ns/1ps

module calc_tb_clk
  #(
    parameter int period_ns_p    = 20,
    parameter int reset_cycles_p = 16
  )
  (
    output logic clk_o,
    output logic arst_n_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_ns_p / 2) clk_o = ~clk_o;
  end

  // Release reset away from the clock edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    #2 arst_n_o = 1'b1;
  end

endmodule

//--- flist.f
hw/calc_isa_pkg.sv
hw/calc_pipe_pkg.sv
hw/calc_issue.sv
hw/calc_pipe_int.sv
hw/calc_pipe_mul.sv
hw/calc_pipe_long.sv
hw/calc_comp_pipe.sv
hw/calc_top.sv
bench/calc_tb_clk.sv
bench/calc_tb.sv

//--- hw/calc_comp_pipe.sv
// Completion pipeline: carries fixed latency results to writeback, feeds bypass and slots in divides
`timescale 1ns/1ps

module calc_comp_pipe
  #(parameter int mul_latency_p = 3)
  (
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,
    input  calc_pipe_pkg::reservation_s             reservation_i,
    input  logic                                    flush_i,
    input  logic [calc_isa_pkg::data_width_c-1:0]   int_result_i,
    input  logic [calc_isa_pkg::data_width_c-1:0]   mul_result_i,
    input  logic                                    long_v_i,
    input  calc_pipe_pkg::wb_pkt_s                  long_wb_i,
    output logic                                    long_ready_o,
    output calc_pipe_pkg::comp_entry_s [mul_latency_p:0] fwd_o,
    output logic                                    wb_v_o,
    output calc_pipe_pkg::wb_pkt_s                  wb_pkt_o
  );

  import calc_pipe_pkg::*;

  localparam int last_c = mul_latency_p - 1;

  comp_entry_s                     stage0;
  comp_entry_s [mul_latency_p-1:0] comp_n;
  comp_entry_s [mul_latency_p-1:0] comp_r;

  // Multiplies enter as a marker and pick up their data at the last stage
  always_comb
  begin
    stage0.w_v     = reservation_i.v & reservation_i.decode.w_v;
    stage0.mul_v   = reservation_i.v & reservation_i.decode.mul_v;
    stage0.rd_addr = reservation_i.instr.rtype.rd;
    stage0.rd_data = int_result_i;

    for (int i = 0; i < mul_latency_p; i++)
      comp_n[i] = (i == 0) ? stage0 : comp_r[i-1];

    if (comp_n[last_c].mul_v)
      comp_n[last_c].rd_data = mul_result_i;

    // Poison everything that has not reached the writeback port
    if (flush_i)
    begin
      for (int i = 0; i < mul_latency_p; i++)
        comp_n[i].w_v = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      comp_r <= '0;
    else
      comp_r <= comp_n;
  end

  // Multiply entries have no data before the last stage
  always_comb
  begin
    fwd_o[0]     = comp_n[0];
    fwd_o[0].w_v = comp_n[0].w_v & ~comp_n[0].mul_v;
    for (int i = 0; i < mul_latency_p; i++)
    begin
      fwd_o[i+1]     = comp_r[i];
      fwd_o[i+1].w_v = comp_r[i].w_v & ~(comp_r[i].mul_v & (i < last_c));
    end
  end

  assign long_ready_o = long_v_i & ~comp_r[last_c].w_v;
  assign wb_v_o       = comp_r[last_c].w_v | long_v_i;

  always_comb
  begin
    if (comp_r[last_c].w_v)
    begin
      wb_pkt_o.rd_addr = comp_r[last_c].rd_addr;
      wb_pkt_o.rd_data = comp_r[last_c].rd_data;
    end
    else
      wb_pkt_o = long_wb_i;
  end

endmodule

//--- hw/calc_isa_pkg.sv
// Instruction word encoding and data path width of the execution back end, imported by RTL and bench
package calc_isa_pkg;

  localparam int data_width_c     = 32;
  localparam int reg_addr_width_c = 5;
  localparam int opcode_width_c   = 4;
  localparam int imm_width_c      = 18;

  // Bits left over in a register-type word
  localparam int rtype_pad_width_c = data_width_c - opcode_width_c - 3 * reg_addr_width_c;

  typedef enum logic [opcode_width_c-1:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_addi = 4'd5,
    op_mul  = 4'd6,
    op_div  = 4'd7,
    op_rem  = 4'd8
  } opcode_e;

  typedef struct packed {
    opcode_e                     opcode;
    logic [reg_addr_width_c-1:0] rd;
    logic [reg_addr_width_c-1:0] rs1;
    logic [reg_addr_width_c-1:0] rs2;
    logic [rtype_pad_width_c-1:0] unused;
  } rtype_s;

  // Opcode, rd and rs1 sit at the same bits as in rtype_s
  typedef struct packed {
    opcode_e                         opcode;
    logic [reg_addr_width_c-1:0]     rd;
    logic [reg_addr_width_c-1:0]     rs1;
    logic signed [imm_width_c-1:0]   imm;
  } itype_s;

  typedef union packed {
    rtype_s rtype;
    itype_s itype;
  } instr_u;

endpackage

//--- hw/calc_issue.sv
// Issue stage: decodes the dispatch packet, bypasses operands and holds the reservation register
`timescale 1ns/1ps

module calc_issue
  #(parameter int mul_latency_p = 3)
  (
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,
    input  logic                                    dispatch_v_i,
    input  calc_pipe_pkg::dispatch_pkt_s            dispatch_pkt_i,
    output logic                                    dispatch_ready_o,
    input  logic                                    flush_i,
    input  logic                                    long_idle_i,
    input  calc_pipe_pkg::comp_entry_s [mul_latency_p:0] fwd_i,
    output calc_pipe_pkg::reservation_s             reservation_o
  );

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  decode_s      dec;
  reservation_s res_n;
  reservation_s res_r;
  logic         res_v_r;
  logic         ready_en_r;
  logic         long_pending;
  logic         dispatch_xfer;

  // Entry 0 is the youngest, so walk from oldest to youngest and let the last hit stand
  function automatic logic [data_width_c-1:0] bypass_operand(
    input logic [reg_addr_width_c-1:0]  addr,
    input logic [data_width_c-1:0]      rf_data,
    input comp_entry_s [mul_latency_p:0] fwd
  );
    logic [data_width_c-1:0] value;
    value = rf_data;
    for (int i = mul_latency_p; i >= 0; i--)
    begin
      if (fwd[i].w_v && (fwd[i].rd_addr == addr))
        value = fwd[i].rd_data;
    end
    if (addr == '0)
      value = '0;
    return value;
  endfunction

  always_comb
  begin
    dec = '0;
    case (dispatch_pkt_i.instr.rtype.opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_addi:
      begin
        dec.int_v = 1'b1;
        dec.w_v   = 1'b1;
      end
      op_mul:
      begin
        dec.mul_v = 1'b1;
        dec.w_v   = 1'b1;
      end
      op_div, op_rem:
        dec.long_v = 1'b1;
      default:
        dec = '0;
    endcase
  end

  // A divide still waiting in the reservation register has not reached the divider yet
  assign long_pending     = ~long_idle_i | (res_v_r & res_r.decode.long_v);
  assign dispatch_ready_o = ready_en_r & ~flush_i & ~(dec.long_v & long_pending);
  assign dispatch_xfer    = dispatch_v_i & dispatch_ready_o;

  always_comb
  begin
    res_n        = '0;
    res_n.v      = 1'b1;
    res_n.decode = dec;
    res_n.instr  = dispatch_pkt_i.instr;
    res_n.rs1    = bypass_operand(dispatch_pkt_i.instr.rtype.rs1, dispatch_pkt_i.rs1, fwd_i);
    res_n.rs2    = bypass_operand(dispatch_pkt_i.instr.rtype.rs2, dispatch_pkt_i.rs2, fwd_i);
  end

  // No transfer happens in a flush cycle, so the valid bit drops there too
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      res_v_r    <= 1'b0;
      ready_en_r <= 1'b0;
    end
    else
    begin
      res_v_r    <= dispatch_xfer;
      ready_en_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dispatch_xfer)
      res_r <= res_n;
  end

  always_comb
  begin
    reservation_o   = res_r;
    reservation_o.v = res_v_r;
  end

endmodule

//--- hw/calc_pipe_int.sv
// Single cycle integer ALU evaluated on the instruction in the reservation register
`timescale 1ns/1ps

module calc_pipe_int
  (
    input  calc_pipe_pkg::reservation_s             reservation_i,
    output logic [calc_isa_pkg::data_width_c-1:0]   result_o
  );

  import calc_isa_pkg::*;

  logic [data_width_c-1:0] rs1;
  logic [data_width_c-1:0] rs2;
  logic [data_width_c-1:0] imm_sext;

  assign rs1 = reservation_i.rs1;
  assign rs2 = reservation_i.rs2;

  // Immediate is read through the I-type view of the same word
  assign imm_sext = {{(data_width_c - imm_width_c){reservation_i.instr.itype.imm[imm_width_c-1]}},
                     reservation_i.instr.itype.imm};

  always_comb
  begin
    case (reservation_i.instr.rtype.opcode)
      op_add:
        result_o = rs1 + rs2;
      op_sub:
        result_o = rs1 - rs2;
      op_and:
        result_o = rs1 & rs2;
      op_or:
        result_o = rs1 | rs2;
      op_xor:
        result_o = rs1 ^ rs2;
      op_addi:
        result_o = rs1 + imm_sext;
      default:
        result_o = '0;
    endcase
  end

endmodule

//--- hw/calc_pipe_long.sv
// Iterative restoring divider for DIV and REM, holds its result until the writeback slot frees up
`timescale 1ns/1ps

module calc_pipe_long
  (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  calc_pipe_pkg::reservation_s reservation_i,
    input  logic                        flush_i,
    output logic                        idle_o,
    output logic                        long_v_o,
    output calc_pipe_pkg::wb_pkt_s      long_wb_o,
    input  logic                        long_ready_i
  );

  import calc_isa_pkg::*;

  localparam int count_width_c = $clog2(data_width_c);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_done
  } state_e;

  state_e                      state_r;
  logic [count_width_c-1:0]    count_r;
  logic [data_width_c-1:0]     quot_r;
  logic [data_width_c-1:0]     rem_r;
  logic [data_width_c-1:0]     divisor_r;
  logic [reg_addr_width_c-1:0] rd_r;
  logic                        rem_sel_r;
  logic                        start;
  logic [data_width_c:0]       trial;
  logic [data_width_c:0]       diff;

  assign start = (state_r == st_idle) & reservation_i.v & reservation_i.decode.long_v & ~flush_i;

  // Shift the next dividend bit into the partial remainder and try the subtract
  assign trial = {rem_r, quot_r[data_width_c-1]};
  assign diff  = trial - {1'b0, divisor_r};

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= st_idle;
      count_r <= '0;
    end
    else if (flush_i)
      state_r <= st_idle;
    else
    begin
      case (state_r)
        st_idle:
        begin
          if (start)
          begin
            state_r <= st_busy;
            count_r <= '0;
          end
        end
        st_busy:
        begin
          count_r <= count_r + 1'b1;
          if (count_r == '1)
            state_r <= st_done;
        end
        st_done:
        begin
          if (long_ready_i)
            state_r <= st_idle;
        end
        default:
          state_r <= st_idle;
      endcase
    end
  end

  // A zero divisor never borrows, so the quotient fills with ones and the
  // remainder ends up as the dividend
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      quot_r    <= reservation_i.rs1;
      divisor_r <= reservation_i.rs2;
      rem_r     <= '0;
      rd_r      <= reservation_i.instr.rtype.rd;
      rem_sel_r <= (reservation_i.instr.rtype.opcode == op_rem);
    end
    else if (state_r == st_busy)
    begin
      quot_r <= {quot_r[data_width_c-2:0], ~diff[data_width_c]};
      rem_r  <= diff[data_width_c] ? trial[data_width_c-1:0] : diff[data_width_c-1:0];
    end
  end

  assign idle_o            = (state_r == st_idle);
  assign long_v_o          = (state_r == st_done);
  assign long_wb_o.rd_addr = rd_r;
  assign long_wb_o.rd_data = rem_sel_r ? rem_r : quot_r;

endmodule

//--- hw/calc_pipe_mul.sv
// Pipelined multiplier returning the low product word after a fixed number of register stages
`timescale 1ns/1ps

module calc_pipe_mul
  #(parameter int mul_latency_p = 3)
  (
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,
    input  calc_pipe_pkg::reservation_s             reservation_i,
    output logic [calc_isa_pkg::data_width_c-1:0]   result_o
  );

  import calc_isa_pkg::*;

  logic [mul_latency_p-2:0][data_width_c-1:0] prod_r;

  // Product enters in the first stage, then shifts down
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      prod_r <= '0;
    else
    begin
      prod_r[0] <= reservation_i.rs1 * reservation_i.rs2;
      for (int i = 1; i < mul_latency_p - 1; i++)
        prod_r[i] <= prod_r[i-1];
    end
  end

  // Lines up with completion stage mul_latency_p-1
  assign result_o = prod_r[mul_latency_p-2];

endmodule

//--- hw/calc_pipe_pkg.sv
// Packet types passed between the issue stage, the execution pipes and the completion pipeline
package calc_pipe_pkg;

  import calc_isa_pkg::*;

  // One-hot pipe select, w_v marks a fixed latency register write
  typedef struct packed {
    logic int_v;
    logic mul_v;
    logic long_v;
    logic w_v;
  } decode_s;

  // Operands as read from the register file by the dispatcher
  typedef struct packed {
    instr_u                  instr;
    logic [data_width_c-1:0] rs1;
    logic [data_width_c-1:0] rs2;
  } dispatch_pkt_s;

  // Instruction held for execution, operands already bypassed
  typedef struct packed {
    logic                    v;
    decode_s                 decode;
    instr_u                  instr;
    logic [data_width_c-1:0] rs1;
    logic [data_width_c-1:0] rs2;
  } reservation_s;

  // One slot of the completion pipeline
  typedef struct packed {
    logic                        w_v;
    logic                        mul_v;
    logic [reg_addr_width_c-1:0] rd_addr;
    logic [data_width_c-1:0]     rd_data;
  } comp_entry_s;

  typedef struct packed {
    logic [reg_addr_width_c-1:0] rd_addr;
    logic [data_width_c-1:0]     rd_data;
  } wb_pkt_s;

endpackage

//--- hw/calc_top.sv
// Execution back end top level: issue stage, ALU, multiplier, divider and completion pipeline
`timescale 1ns/1ps

module calc_top
  #(parameter int mul_latency_p = 3)
  (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         dispatch_v_i,
    input  calc_pipe_pkg::dispatch_pkt_s dispatch_pkt_i,
    output logic                         dispatch_ready_o,
    input  logic                         flush_i,
    output logic                         wb_v_o,
    output calc_pipe_pkg::wb_pkt_s       wb_pkt_o,
    output logic                         long_busy_o
  );

  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;

  reservation_s                 reservation;
  comp_entry_s [mul_latency_p:0] fwd;
  logic [data_width_c-1:0]      int_result;
  logic [data_width_c-1:0]      mul_result;
  logic                         long_idle;
  logic                         long_v;
  logic                         long_ready;
  wb_pkt_s                      long_wb;

  calc_issue #(.mul_latency_p(mul_latency_p)) issue (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .dispatch_v_i     (dispatch_v_i),
    .dispatch_pkt_i   (dispatch_pkt_i),
    .dispatch_ready_o (dispatch_ready_o),
    .flush_i          (flush_i),
    .long_idle_i      (long_idle),
    .fwd_i            (fwd),
    .reservation_o    (reservation)
  );

  calc_pipe_int pipe_int (
    .reservation_i (reservation),
    .result_o      (int_result)
  );

  calc_pipe_mul #(.mul_latency_p(mul_latency_p)) pipe_mul (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reservation_i (reservation),
    .result_o      (mul_result)
  );

  calc_pipe_long pipe_long (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reservation_i (reservation),
    .flush_i       (flush_i),
    .idle_o        (long_idle),
    .long_v_o      (long_v),
    .long_wb_o     (long_wb),
    .long_ready_i  (long_ready)
  );

  calc_comp_pipe #(.mul_latency_p(mul_latency_p)) comp_pipe (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reservation_i (reservation),
    .flush_i       (flush_i),
    .int_result_i  (int_result),
    .mul_result_i  (mul_result),
    .long_v_i      (long_v),
    .long_wb_i     (long_wb),
    .long_ready_o  (long_ready),
    .fwd_o         (fwd),
    .wb_v_o        (wb_v_o),
    .wb_pkt_o      (wb_pkt_o)
  );

  assign long_busy_o = ~long_idle;

endmodule
